// File: Bender.yml
package:
  name: owt_rx

sources:
  - files:
      - verilog/owt_rx_pkg.sv
      - verilog/owt_symbol_timer.sv
      - verilog/owt_mcst_decoder.sv
      - verilog/owt_crc8_serial.sv
      - verilog/owt_frame_fsm.sv
      - verilog/owt_com_err_monitor.sv
      - verilog/owt_rx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/owt_rx_tb.sv

// File: owt_rx_top.f
+incdir+include
verilog/owt_rx_pkg.sv
verilog/owt_symbol_timer.sv
verilog/owt_mcst_decoder.sv
verilog/owt_crc8_serial.sv
verilog/owt_frame_fsm.sv
verilog/owt_com_err_monitor.sv
verilog/owt_rx_top.sv
tb/owt_rx_tb.sv

// File: include/owt_rx_tb_tasks.svh
`ifndef OWT_RX_TB_TASKS_SVH
`define OWT_RX_TB_TASKS_SVH

// one half-bit symbol, held for HB_CYC clocks
task automatic drive_half(input logic lvl);
    @(posedge clk);
    owt_rx <= lvl;
    repeat (HB_CYC - 1) @(posedge clk);
endtask

// manchester bit, 1 is high then low
task automatic drive_manchester(input logic b);
    drive_half(b);
    drive_half(~b);
endtask

// whole frame, cut short where the receiver aborts
task automatic drive_frame(input logic [7:0] cmd, input logic [15:0] data, input int dbits,
                           input logic [7:0] crc, input logic [3:0] stail,
                           input logic [3:0] etail, input bit inv_cmd);
    int i;
    // sync head starts high
    for (i = 0; i < 8; i++) drive_half(i % 2 == 0);
    for (i = 3; i >= 0; i--) drive_half(stail[i]);
    if (stail != TAIL_OK) begin
        return;
    end
    if (inv_cmd) begin
        // equal halves in the first command bit
        drive_half(1'b1);
        drive_half(1'b1);
        return;
    end
    for (i = 7; i >= 0; i--) drive_manchester(cmd[i]);
    for (i = dbits - 1; i >= 0; i--) drive_manchester(data[i]);
    for (i = 7; i >= 0; i--) drive_manchester(crc[i]);
    for (i = 3; i >= 0; i--) drive_half(etail[i]);
endtask

`endif

// File: tb/owt_rx_tb.sv
`default_nettype none

module owt_rx_tb
    import owt_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int HB_CYC   = 8;
    localparam int FRAME_HB = 80;
    localparam int GAP_MAX  = 160;
    localparam int N_FRAMES = 28;
    localparam int WDOG_CYC = 2 * N_FRAMES * (FRAME_HB * HB_CYC + GAP_MAX) + 500;
    localparam logic [3:0] TAIL_OK = 4'b1100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        owt_rx;
    comerr_cfg_t comerr_cfg;
    logic        rx_ack;
    rx_frame_t   rx_frame;
    logic        com_err;

    // reference model
    rx_frame_t   exp_frame;
    logic [7:0]  last_cmd;
    logic [15:0] last_data;
    int          score_m;
    logic        exp_com_err;

    logic        ack_q1 = 1'b0;
    logic        ack_q2 = 1'b0;
    int          ack_cnt = 0;
    string       test_name = "reset";
    int          errors = 0;
    int          test_err0 = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    always #50 clk = ~clk;

    owt_rx_top #(
        .SYM_CNT_W(8)
    ) dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_owt_rx    (owt_rx),
        .i_comerr_cfg(comerr_cfg),
        .o_rx_ack    (rx_ack),
        .o_rx_frame  (rx_frame),
        .o_com_err   (com_err)
    );

    `include "owt_rx_tb_tasks.svh"

    always @(posedge clk) begin
        ack_q1 <= rx_ack;
        ack_q2 <= ack_q1;
        if (rx_ack) begin
            ack_cnt <= ack_cnt + 1;
        end
    end

    // ====================
    // checks
    // ====================
    frame_chk: assert property (@(posedge clk) disable iff (!rst_n)
        rx_ack |-> (rx_frame == exp_frame))
        else begin
            $display("ERROR: %s rx_frame expected %h actual %h", test_name, exp_frame, rx_frame);
            errors++;
        end

    // level settles two cycles after the ack
    com_err_chk: assert property (@(posedge clk) disable iff (!rst_n)
        ack_q2 |-> (com_err == exp_com_err))
        else begin
            $display("ERROR: %s com_err expected %b actual %b", test_name, exp_com_err, com_err);
            errors++;
        end

    task automatic compare_bit(input string what, input logic exp, input logic act);
        value_chk: assert (act === exp)
            else begin
                $display("ERROR: %s %s expected %b actual %b", test_name, what, exp, act);
                errors++;
            end
    endtask

    function automatic logic [7:0] crc8_ref(input logic [23:0] bits, input int n);
        logic [7:0] c;
        logic       fb;
        int         i;
        c = 8'h00;
        for (i = n - 1; i >= 0; i--) begin
            fb = c[7] ^ bits[i];
            c  = {c[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
        end
        return c;
    endfunction

    function automatic int score_ref(input int s, input logic bad, input comerr_cfg_t c);
        int add_step;
        int sub_step;
        add_step = 4 * (int'(c.add_sel) + 1);
        sub_step = int'(c.sub_sel) + 1;
        if (bad) begin
            return (s + add_step > 31) ? 31 : s + add_step;
        end
        return (s < sub_step) ? 0 : s - sub_step;
    endfunction

    function automatic logic com_err_ref(input int s, input comerr_cfg_t c);
        return c.mode ? (s == 0) : (s >= 4 * (int'(c.add_sel) + 1));
    endfunction

    // ====================
    // frame with model update
    // ====================
    task automatic send_frame(input logic [7:0] cmd, input logic [15:0] data,
                              input logic [7:0] crc_flip, input logic [3:0] stail,
                              input logic [3:0] etail, input bit inv_cmd);
        int         dbits;
        int         n0;
        int         k;
        logic [7:0] crc;
        dbits = (cmd == 8'h1f) ? 16 : 8;
        crc   = (dbits == 16) ? crc8_ref({cmd, data}, 24) : crc8_ref({8'h00, cmd, data[7:0]}, 16);
        // aborted frames leave the fields of the last full frame
        if (inv_cmd || (stail != TAIL_OK)) begin
            exp_frame = {last_cmd, last_data, 1'b1};
        end else begin
            last_cmd  = cmd;
            last_data = (dbits == 16) ? data : {8'h00, data[7:0]};
            exp_frame = {cmd, last_data, (crc_flip != 8'h00) || (etail != TAIL_OK)};
        end
        score_m     = score_ref(score_m, exp_frame.status, comerr_cfg);
        exp_com_err = com_err_ref(score_m, comerr_cfg);
        n0 = ack_cnt;
        drive_frame(cmd, data, dbits, crc ^ crc_flip, stail, etail, inv_cmd);
        @(posedge clk);
        owt_rx <= 1'b0;
        k = 0;
        while ((ack_cnt == n0) && (k < 64)) begin
            @(posedge clk);
            k++;
        end
        repeat (40 + $urandom % 40) @(posedge clk);
        if (ack_cnt != n0 + 1) begin
            $display("%s saw %0d acks for one frame instead of one", test_name, ack_cnt - n0);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            n_pass++;
            $display("test %-14s passed", test_name);
        end else begin
            n_fail++;
            $display("test %-14s failed with %0d errors", test_name, errors - test_err0);
        end
    endtask

    // ====================
    // sequence
    // ====================
    initial begin
        logic [1:0] add_sel;
        logic [1:0] sub_sel;
        logic       bad;
        int         mode;
        int         i;
        void'($urandom(32'hc44c));
        rst_n       = 1'b0;
        owt_rx      = 1'b0;
        comerr_cfg  = '0;
        score_m     = 16;
        exp_com_err = 1'b1;
        exp_frame   = '0;
        start_test("reset");
        repeat (15) @(posedge clk);
        @(negedge clk);
        compare_bit("o_rx_ack in reset", 1'b0, rx_ack);
        compare_bit("o_com_err in reset", 1'b1, com_err);
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(negedge clk);
        compare_bit("o_com_err after reset", 1'b1, com_err);
        end_test();

        start_test("good_rw");
        send_frame(8'h85, 16'h003c, 8'h00, TAIL_OK, TAIL_OK, 1'b0);
        send_frame(8'h12, 16'h00a7, 8'h00, TAIL_OK, TAIL_OK, 1'b0);
        end_test();

        start_test("adc_read");
        send_frame(8'h1f, 16'hbeef, 8'h00, TAIL_OK, TAIL_OK, 1'b0);
        end_test();

        start_test("bad_crc_tail");
        send_frame(8'h9f, 16'h0055, 8'h01, TAIL_OK, TAIL_OK, 1'b0);
        send_frame(8'h23, 16'h00c3, 8'h00, TAIL_OK, 4'b1010, 1'b0);
        end_test();

        start_test("abort_recover");
        send_frame(8'h44, 16'h0011, 8'h00, TAIL_OK, TAIL_OK, 1'b1);
        send_frame(8'h45, 16'h0022, 8'h00, 4'b1010, TAIL_OK, 1'b0);
        send_frame(8'h46, 16'h0033, 8'h00, TAIL_OK, TAIL_OK, 1'b0);
        end_test();

        for (mode = 0; mode < 2; mode++) begin
            add_sel = 2'($urandom % 4);
            sub_sel = 2'($urandom % 4);
            start_test(mode ? "com_err_mode1" : "com_err_mode0");
            @(posedge clk);
            comerr_cfg <= {mode[0], add_sel, sub_sel};
            @(posedge clk);
            for (i = 0; i < 10; i++) begin
                bad = ($urandom % 3 == 0);
                send_frame(8'($urandom), 16'($urandom), {7'h00, bad}, TAIL_OK, TAIL_OK, 1'b0);
            end
            end_test();
        end

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // bound from the longest frame and gap
    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished", WDOG_CYC);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/owt_com_err_monitor.sv
`default_nettype none

module owt_com_err_monitor
    import owt_rx_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_ack,
    input  wire logic        i_status,
    input  wire comerr_cfg_t i_cfg,
    output logic             o_com_err
);

    logic [OWT_ERR_CNT_W-1:0] score;
    logic [OWT_ERR_CNT_W-1:0] add_step;
    logic [OWT_ERR_CNT_W-1:0] sub_step;
    logic [OWT_ERR_CNT_W:0]   sum;
    logic                     err_lvl;

    assign add_step = OWT_ERR_ADD_STEP[i_cfg.add_sel];
    assign sub_step = OWT_COR_SUB_STEP[i_cfg.sub_sel];
    assign sum      = {1'b0, score} + {1'b0, add_step};

    // bad frames push up, good frames pull down
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            score <= OWT_ERR_INIT;
        end else if (i_ack && i_status) begin
            if (sum >= {1'b0, OWT_ERR_MAX}) begin
                score <= OWT_ERR_MAX;
            end else begin
                score <= sum[OWT_ERR_CNT_W-1:0];
            end
        end else if (i_ack) begin
            if (sub_step >= score) begin
                score <= '0;
            end else begin
                score <= score - sub_step;
            end
        end
    end

    // mode 1 flags an empty score
    assign err_lvl = i_cfg.mode ? (score == '0) : (score >= add_step);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_com_err <= 1'b1;
        end else begin
            o_com_err <= err_lvl;
        end
    end

endmodule

`default_nettype wire

// File: verilog/owt_crc8_serial.sv
`default_nettype none

module owt_crc8_serial
    import owt_rx_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_vld,
    input  wire logic        i_start,
    input  wire logic        i_bit,
    output logic [7:0]       o_crc
);

    logic [7:0] crc_base;
    logic       fb;
    logic [7:0] crc_nxt;

    // restart from zero on the first bit
    assign crc_base = i_start ? 8'h00 : o_crc;
    assign fb       = crc_base[7] ^ i_bit;
    assign crc_nxt  = {crc_base[6:0], 1'b0} ^ (fb ? CRC8_POLY : 8'h00);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_crc <= 8'h00;
        end else if (i_vld) begin
            o_crc <= crc_nxt;
        end
    end

endmodule

`default_nettype wire

// File: verilog/owt_frame_fsm.sv
`default_nettype none

module owt_frame_fsm
    import owt_rx_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_rise,
    input  wire logic      i_head_done,
    input  wire half_bit_t i_half,
    input  wire mcst_bit_t i_bit,
    input  wire logic [7:0] i_crc,
    output logic           o_head,
    output logic           o_clear,
    output logic           o_dec_en,
    output logic           o_crc_vld,
    output logic           o_crc_start,
    output logic           o_crc_bit,
    output rx_frame_t      o_frame,
    output logic           o_ack
);

    owt_rx_state_e state;
    owt_rx_state_e state_nxt;

    logic [OWT_BIT_CNT_W-1:0] cnt;
    logic [OWT_BIT_CNT_W-1:0] cnt_last;
    logic                     in_tail;
    logic                     tick;
    logic                     last;
    logic [OWT_TAIL_BITS-1:0] tail_sr;
    logic                     tail_ok;
    logic [OWT_CMD_BITS-1:0]  cmd_sr;
    logic [OWT_CMD_BITS-1:0]  cmd_nxt;
    logic [OWT_ADCD_BITS-1:0] data_sr;
    logic [OWT_CRC_BITS-1:0]  crc_rx;
    logic                     going_idle;
    logic                     fin_q;
    logic                     status_q;

    assign in_tail  = (state == SYNC_TAIL) || (state == END_TAIL);
    assign o_head   = (state == SYNC_HEAD);
    assign o_clear  = (state == IDLE);
    assign o_dec_en = (state == CMD) || (state == ADC_DATA) || (state == NML_DATA) ||
                      (state == CRC);

    assign tick    = in_tail ? i_half.strobe : (o_dec_en & i_bit.vld);
    assign tail_ok = ({tail_sr[OWT_TAIL_BITS-2:0], i_half.level} == OWT_TAIL_PATTERN);
    assign cmd_nxt = {cmd_sr[OWT_CMD_BITS-2:0], i_bit.value};

    // field length by state
    always_comb begin
        case (state)
            CMD:      cnt_last = OWT_BIT_CNT_W'(OWT_CMD_BITS - 1);
            ADC_DATA: cnt_last = OWT_BIT_CNT_W'(OWT_ADCD_BITS - 1);
            NML_DATA: cnt_last = OWT_BIT_CNT_W'(OWT_DATA_BITS - 1);
            CRC:      cnt_last = OWT_BIT_CNT_W'(OWT_CRC_BITS - 1);
            default:  cnt_last = OWT_BIT_CNT_W'(OWT_TAIL_BITS - 1);
        endcase
    end

    assign last = tick & (cnt == cnt_last);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (i_rise) state_nxt = SYNC_HEAD;
            SYNC_HEAD: if (i_head_done) state_nxt = SYNC_TAIL;
            SYNC_TAIL: if (last) state_nxt = tail_ok ? CMD : IDLE;
            CMD: begin
                if (i_bit.invld) begin
                    state_nxt = IDLE;
                end else if (last) begin
                    // reads with the ADC code carry 16 data bits
                    if (!cmd_nxt[OWT_CMD_BITS-1] &&
                        (cmd_nxt[OWT_CMD_BITS-2:0] == OWT_ADC_RD_CODE)) begin
                        state_nxt = ADC_DATA;
                    end else begin
                        state_nxt = NML_DATA;
                    end
                end
            end
            ADC_DATA, NML_DATA: begin
                if (i_bit.invld) state_nxt = IDLE;
                else if (last) state_nxt = CRC;
            end
            CRC: begin
                if (i_bit.invld) state_nxt = IDLE;
                else if (last) state_nxt = END_TAIL;
            end
            END_TAIL:  if (last) state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (state_nxt != state) begin
                cnt <= '0;
            end else if (tick) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // ====================
    // field shift registers
    // ====================
    always_ff @(posedge i_clk) begin
        if (in_tail && i_half.strobe) begin
            tail_sr <= {tail_sr[OWT_TAIL_BITS-2:0], i_half.level};
        end
        if ((state == CMD) && i_bit.vld) begin
            cmd_sr <= cmd_nxt;
        end
        if (o_crc_start) begin
            data_sr <= '0;
        end else if (((state == ADC_DATA) || (state == NML_DATA)) && i_bit.vld) begin
            data_sr <= {data_sr[OWT_ADCD_BITS-2:0], i_bit.value};
        end
        if ((state == CRC) && i_bit.vld) begin
            crc_rx <= {crc_rx[OWT_CRC_BITS-2:0], i_bit.value};
        end
    end

    assign o_crc_vld   = i_bit.vld & ((state == CMD) || (state == ADC_DATA) ||
                                      (state == NML_DATA));
    assign o_crc_start = i_bit.vld & (state == CMD) & (cnt == '0);
    assign o_crc_bit   = i_bit.value;

    // ====================
    // status and ack
    // ====================
    assign going_idle = (state != IDLE) && (state_nxt == IDLE);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            fin_q    <= 1'b0;
            o_ack    <= 1'b0;
            status_q <= 1'b0;
        end else begin
            fin_q <= going_idle;
            o_ack <= fin_q;
            if (going_idle) begin
                status_q <= (state != END_TAIL) | ~tail_ok | (crc_rx != i_crc);
            end
        end
    end

    assign o_frame.cmd    = cmd_sr;
    assign o_frame.data   = data_sr;
    assign o_frame.status = status_q;

endmodule

`default_nettype wire

// File: verilog/owt_mcst_decoder.sv
`default_nettype none

module owt_mcst_decoder
    import owt_rx_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst_n,
    input  wire logic      i_en,
    input  wire half_bit_t i_half,
    output mcst_bit_t      o_bit
);

    logic phase;
    logic first_lvl;

    // phase 0 waits for first half, phase 1 for second
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase     <= 1'b0;
            first_lvl <= 1'b0;
        end else if (!i_en) begin
            phase <= 1'b0;
        end else if (i_half.strobe) begin
            phase <= ~phase;
            if (!phase) begin
                first_lvl <= i_half.level;
            end
        end
    end

    // 1 then 0 is a one, equal halves are invalid
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bit <= '0;
        end else begin
            o_bit.vld   <= i_en & i_half.strobe & phase & (first_lvl ^ i_half.level);
            o_bit.invld <= i_en & i_half.strobe & phase & ~(first_lvl ^ i_half.level);
            o_bit.value <= first_lvl;
        end
    end

endmodule

`default_nettype wire

// File: verilog/owt_rx_pkg.sv
`default_nettype none

package owt_rx_pkg;

    // ====================
    // frame field lengths
    // ====================
    localparam int OWT_SYNC_EDGES = 8;
    localparam int OWT_TAIL_BITS  = 4;
    localparam logic [OWT_TAIL_BITS-1:0] OWT_TAIL_PATTERN = 4'b1100;
    localparam int OWT_CMD_BITS   = 8;
    localparam int OWT_DATA_BITS  = 8;
    localparam int OWT_ADCD_BITS  = 16;
    localparam int OWT_CRC_BITS   = 8;
    localparam logic [OWT_CMD_BITS-2:0] OWT_ADC_RD_CODE = 7'h1f;
    localparam logic [OWT_CRC_BITS-1:0] CRC8_POLY = 8'h07;

    // wide enough for the longest field
    localparam int OWT_BIT_CNT_W = 5;

    // ====================
    // error monitor
    // ====================
    localparam int OWT_ERR_CNT_W = 5;
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_MAX  = 5'd31;
    localparam logic [OWT_ERR_CNT_W-1:0] OWT_ERR_INIT = 5'd16;

    // index 0 is the rightmost entry
    localparam logic [3:0][OWT_ERR_CNT_W-1:0] OWT_ERR_ADD_STEP = {5'd16, 5'd12, 5'd8, 5'd4};
    localparam logic [3:0][OWT_ERR_CNT_W-1:0] OWT_COR_SUB_STEP = {5'd4, 5'd3, 5'd2, 5'd1};

    typedef enum logic [2:0] {
        IDLE,
        SYNC_HEAD,
        SYNC_TAIL,
        CMD,
        ADC_DATA,
        NML_DATA,
        CRC,
        END_TAIL
    } owt_rx_state_e;

    // one sampled half-bit
    typedef struct packed {
        logic strobe;
        logic level;
    } half_bit_t;

    typedef struct packed {
        logic vld;
        logic value;
        logic invld;
    } mcst_bit_t;

    typedef struct packed {
        logic       mode;
        logic [1:0] add_sel;
        logic [1:0] sub_sel;
    } comerr_cfg_t;

    typedef struct packed {
        logic [OWT_CMD_BITS-1:0]  cmd;
        logic [OWT_ADCD_BITS-1:0] data;
        logic                     status;
    } rx_frame_t;

endpackage

`default_nettype wire

// File: verilog/owt_rx_top.sv
`default_nettype none

module owt_rx_top
    import owt_rx_pkg::*;
#(
    parameter int SYM_CNT_W = 8
) (
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,
    input  wire logic        i_owt_rx,
    input  wire comerr_cfg_t i_comerr_cfg,
    output logic             o_rx_ack,
    output rx_frame_t        o_rx_frame,
    output logic             o_com_err
);

    logic       rise;
    logic       head_done;
    logic       head;
    logic       clear;
    logic       dec_en;
    half_bit_t  half;
    mcst_bit_t  mbit;
    logic       crc_vld;
    logic       crc_start;
    logic       crc_bit;
    logic [7:0] crc;

    owt_symbol_timer #(
        .SYM_CNT_W(SYM_CNT_W)
    ) u_timer (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_line     (i_owt_rx),
        .i_head     (head),
        .i_clear    (clear),
        .o_rise     (rise),
        .o_head_done(head_done),
        .o_half     (half)
    );

    owt_mcst_decoder u_decoder (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_en   (dec_en),
        .i_half (half),
        .o_bit  (mbit)
    );

    owt_frame_fsm u_fsm (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rise     (rise),
        .i_head_done(head_done),
        .i_half     (half),
        .i_bit      (mbit),
        .i_crc      (crc),
        .o_head     (head),
        .o_clear    (clear),
        .o_dec_en   (dec_en),
        .o_crc_vld  (crc_vld),
        .o_crc_start(crc_start),
        .o_crc_bit  (crc_bit),
        .o_frame    (o_rx_frame),
        .o_ack      (o_rx_ack)
    );

    owt_crc8_serial u_crc (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_vld  (crc_vld),
        .i_start(crc_start),
        .i_bit  (crc_bit),
        .o_crc  (crc)
    );

    owt_com_err_monitor u_err_mon (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ack    (o_rx_ack),
        .i_status (o_rx_frame.status),
        .i_cfg    (i_comerr_cfg),
        .o_com_err(o_com_err)
    );

endmodule

`default_nettype wire

// File: verilog/owt_symbol_timer.sv
`default_nettype none

module owt_symbol_timer
    import owt_rx_pkg::*;
#(
    parameter int SYM_CNT_W = 8
) (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_line,
    input  wire logic i_head,
    input  wire logic i_clear,
    output logic      o_rise,
    output logic      o_head_done,
    output half_bit_t o_half
);

    localparam int EDGE_W = $clog2(OWT_SYNC_EDGES + 1);

    logic                 line_s1;
    logic                 line_s2;
    logic                 line_d;
    logic                 edge_det;
    logic [SYM_CNT_W-1:0] run_cnt;
    logic [SYM_CNT_W-1:0] l_len;
    logic [SYM_CNT_W-1:0] l_nxt;
    logic [SYM_CNT_W-1:0] half_nxt;
    logic [SYM_CNT_W-1:0] tgt;
    logic [EDGE_W-1:0]    edge_cnt;
    logic                 strobe;

    // ====================
    // sync and edges
    // ====================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_s1 <= 1'b0;
            line_s2 <= 1'b0;
            line_d  <= 1'b0;
        end else begin
            line_s1 <= i_line;
            line_s2 <= line_s1;
            line_d  <= line_s2;
        end
    end

    assign edge_det = line_s2 ^ line_d;
    assign o_rise   = line_s2 & ~line_d;

    // run length since last edge, saturating
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_cnt <= SYM_CNT_W'(1);
        end else if (edge_det) begin
            run_cnt <= SYM_CNT_W'(1);
        end else if (run_cnt != {SYM_CNT_W{1'b1}}) begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    // ====================
    // head measurement
    // ====================
    assign l_nxt = (i_head && edge_det && (run_cnt > l_len)) ? run_cnt : l_len;
    assign half_nxt = (l_nxt[SYM_CNT_W-1:1] == '0) ? SYM_CNT_W'(1) : (l_nxt >> 1);
    assign o_head_done = i_head & edge_det & (edge_cnt == EDGE_W'(OWT_SYNC_EDGES - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            edge_cnt <= '0;
        end else if (!i_head) begin
            edge_cnt <= '0;
        end else if (edge_det) begin
            edge_cnt <= edge_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            l_len <= '0;
        end else if (i_clear) begin
            l_len <= '0;
        end else begin
            l_len <= l_nxt;
        end
    end

    // ====================
    // half-bit strobes
    // ====================
    assign strobe = ~edge_det & ~i_head & (l_len != '0) & (run_cnt == tgt);

    // realign on every edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tgt <= '0;
        end else if (edge_det) begin
            tgt <= half_nxt;
        end else if (strobe) begin
            tgt <= tgt + l_len;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_half <= '0;
        end else begin
            o_half.strobe <= strobe;
            o_half.level  <= line_s2;
        end
    end

endmodule

`default_nettype wire
